//--- gpio_pkg.sv
/*
  Shared AXI4-Lite channel types and the GPIO register map.
  Data width and pin count are both fixed at 32. No burst, ID or user fields.
  Row offsets are byte addresses and the low two bits are ignored by the DUT.
*/
package gpio_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 32;
  // One strobe bit per byte lane
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // Response codes on B and R
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam int NUM_ROWS = 4;
  // Row index bits plus the byte lane bits
  localparam int ROW_OFF_WIDTH = $clog2(NUM_ROWS) + 2;

  // Synchronized pin input, read only
  localparam logic [ROW_OFF_WIDTH-1:0] ROW_RDATA = 'h0;
  localparam logic [ROW_OFF_WIDTH-1:0] ROW_WDATA = 'h4;
  localparam logic [ROW_OFF_WIDTH-1:0] ROW_WEN   = 'h8;
  localparam logic [ROW_OFF_WIDTH-1:0] ROW_PULL  = 'hC;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [2:0]                prot;
  } axi4l_aw_t;

  // Same layout as AW
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [2:0]                prot;
  } axi4l_ar_t;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
  } axi4l_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi4l_b_t;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [1:0]                resp;
  } axi4l_r_t;

  // Everything the master drives
  typedef struct packed {
    axi4l_aw_t aw;
    logic      aw_valid;
    axi4l_w_t  w;
    logic      w_valid;
    logic      b_ready;
    axi4l_ar_t ar;
    logic      ar_valid;
    logic      r_ready;
  } axi4l_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    axi4l_b_t b;
    logic     b_valid;
    logic     ar_ready;
    axi4l_r_t r;
    logic     r_valid;
  } axi4l_resp_t;

endpackage

//--- axi_lite_fifo.sv
/*
  Elastic buffer for one valid/ready channel.
  Accepts a push while full if the head is popped in the same cycle.
  Storage has no reset, so out_data_o is undefined while out_valid_o is low.
*/
module axi_lite_fifo #(
  parameter int  FIFO_DEPTH = 4,
  parameter type payload_t  = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Write side
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  // Read side
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  payload_t             mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;
  logic                 full;
  logic                 push;
  logic                 pop;

  // Pointer wrap for any depth, not just powers of two
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count_q == CNT_WIDTH'(FIFO_DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem[rd_ptr_q];
  // Room also when the head leaves this cycle
  assign in_ready_o  = !full || out_ready_i;
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- axi_lite_buffer.sv
/*
  One FIFO per AXI4-Lite channel between the port and the register side.
  AW, W and AR run toward the register file, B and R run back out.
  All five FIFOs share the same depth.
*/
module axi_lite_buffer
  import gpio_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // External master side
  input  axi4l_req_t  req_i,
  output axi4l_resp_t resp_o,
  // Register file side
  output axi4l_req_t  req_o,
  input  axi4l_resp_t resp_i
);

  //////////////////////////////////////////////////
  // Per-channel signals on the register side
  //////////////////////////////////////////////////

  axi4l_aw_t aw_data;
  logic      aw_valid;
  logic      aw_ready_ext;
  axi4l_w_t  w_data;
  logic      w_valid;
  logic      w_ready_ext;
  axi4l_ar_t ar_data;
  logic      ar_valid;
  logic      ar_ready_ext;

  // Response channels seen from the master
  axi4l_b_t  b_data;
  logic      b_valid;
  logic      b_ready_int;
  axi4l_r_t  r_data;
  logic      r_valid;
  logic      r_ready_int;

  //////////////////////////////////////////////////
  // Request direction
  //////////////////////////////////////////////////

  axi_lite_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .payload_t (axi4l_aw_t)
  ) aw_fifo_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_data_i  (req_i.aw),
    .in_valid_i (req_i.aw_valid),
    .in_ready_o (aw_ready_ext),
    .out_data_o (aw_data),
    .out_valid_o(aw_valid),
    .out_ready_i(resp_i.aw_ready)
  );

  axi_lite_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .payload_t (axi4l_w_t)
  ) w_fifo_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_data_i  (req_i.w),
    .in_valid_i (req_i.w_valid),
    .in_ready_o (w_ready_ext),
    .out_data_o (w_data),
    .out_valid_o(w_valid),
    .out_ready_i(resp_i.w_ready)
  );

  axi_lite_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .payload_t (axi4l_ar_t)
  ) ar_fifo_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_data_i  (req_i.ar),
    .in_valid_i (req_i.ar_valid),
    .in_ready_o (ar_ready_ext),
    .out_data_o (ar_data),
    .out_valid_o(ar_valid),
    .out_ready_i(resp_i.ar_ready)
  );

  //////////////////////////////////////////////////
  // Response direction
  //////////////////////////////////////////////////

  axi_lite_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .payload_t (axi4l_b_t)
  ) b_fifo_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_data_i  (resp_i.b),
    .in_valid_i (resp_i.b_valid),
    .in_ready_o (b_ready_int),
    .out_data_o (b_data),
    .out_valid_o(b_valid),
    .out_ready_i(req_i.b_ready)
  );

  axi_lite_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .payload_t (axi4l_r_t)
  ) r_fifo_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_data_i  (resp_i.r),
    .in_valid_i (resp_i.r_valid),
    .in_ready_o (r_ready_int),
    .out_data_o (r_data),
    .out_valid_o(r_valid),
    .out_ready_i(req_i.r_ready)
  );

  // Repack into bundles
  always_comb begin
    req_o.aw       = aw_data;
    req_o.aw_valid = aw_valid;
    req_o.w        = w_data;
    req_o.w_valid  = w_valid;
    // B and R readiness means room in the response FIFOs
    req_o.b_ready  = b_ready_int;
    req_o.ar       = ar_data;
    req_o.ar_valid = ar_valid;
    req_o.r_ready  = r_ready_int;
  end

  always_comb begin
    resp_o.aw_ready = aw_ready_ext;
    resp_o.w_ready  = w_ready_ext;
    resp_o.b        = b_data;
    resp_o.b_valid  = b_valid;
    resp_o.ar_ready = ar_ready_ext;
    resp_o.r        = r_data;
    resp_o.r_valid  = r_valid;
  end

endmodule

//--- gpio_regfile.sv
/*
  GPIO registers behind the buffered AXI4-Lite channels.
  AW and W are consumed only as a pair. SLVERR for prot[1] set, for an address
  above the last row, and for writes to the input row. No interrupts.
*/
module gpio_regfile
  import gpio_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Bus side
  input  axi4l_req_t                req_i,
  output axi4l_resp_t               resp_o,
  // Pins
  input  logic [AXI_DATA_WIDTH-1:0] gpio_in_i,
  output logic [AXI_DATA_WIDTH-1:0] gpio_o,
  output logic [AXI_DATA_WIDTH-1:0] gpio_oe_o,
  output logic [AXI_DATA_WIDTH-1:0] gpio_pull_o
);

  // Control registers
  logic [AXI_DATA_WIDTH-1:0] wdata_q;
  logic [AXI_DATA_WIDTH-1:0] wen_q;
  logic [AXI_DATA_WIDTH-1:0] pull_q;

  // Decode
  logic [ROW_OFF_WIDTH-1:0]  wr_off;
  logic [ROW_OFF_WIDTH-1:0]  rd_off;
  logic                      wr_fire;
  logic                      wr_ok;
  logic                      rd_ok;
  logic [AXI_DATA_WIDTH-1:0] rd_row_data;

  // Replace only the strobed byte lanes
  function automatic logic [AXI_DATA_WIDTH-1:0] strb_merge(
    input logic [AXI_DATA_WIDTH-1:0] old_v,
    input logic [AXI_DATA_WIDTH-1:0] new_v,
    input logic [AXI_STRB_WIDTH-1:0] strb
  );
    logic [AXI_DATA_WIDTH-1:0] res;
    res = old_v;
    for (int lane = 0; lane < AXI_STRB_WIDTH; lane++) begin
      if (strb[lane]) begin
        res[8*lane+:8] = new_v[8*lane+:8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////

  // Byte lane bits forced to zero
  assign wr_off  = {req_i.aw.addr[ROW_OFF_WIDTH-1:2], 2'b00};
  // Pair present and B FIFO has room
  assign wr_fire = req_i.aw_valid && req_i.w_valid && req_i.b_ready;

  assign wr_ok = !req_i.aw.prot[1]
              && (req_i.aw.addr[AXI_ADDR_WIDTH-1:ROW_OFF_WIDTH] == '0)
              && ((wr_off == ROW_WDATA) || (wr_off == ROW_WEN) || (wr_off == ROW_PULL));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wdata_q <= '0;
      wen_q   <= '0;
      pull_q  <= '0;
    end else if (wr_fire && wr_ok) begin
      case (wr_off)
        ROW_WDATA: wdata_q <= strb_merge(wdata_q, req_i.w.data, req_i.w.strb);
        ROW_WEN:   wen_q   <= strb_merge(wen_q, req_i.w.data, req_i.w.strb);
        ROW_PULL:  pull_q  <= strb_merge(pull_q, req_i.w.data, req_i.w.strb);
        default:   wdata_q <= wdata_q;
      endcase
    end
  end

  assign gpio_o      = wdata_q;
  assign gpio_oe_o   = wen_q;
  assign gpio_pull_o = pull_q;

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  assign rd_off = {req_i.ar.addr[ROW_OFF_WIDTH-1:2], 2'b00};
  assign rd_ok  = !req_i.ar.prot[1]
               && (req_i.ar.addr[AXI_ADDR_WIDTH-1:ROW_OFF_WIDTH] == '0);

  // Row select
  always_comb begin
    case (rd_off)
      ROW_RDATA: rd_row_data = gpio_in_i;
      ROW_WDATA: rd_row_data = wdata_q;
      ROW_WEN:   rd_row_data = wen_q;
      ROW_PULL:  rd_row_data = pull_q;
      default:   rd_row_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Handshakes and responses
  //////////////////////////////////////////////////

  always_comb begin
    // AW and W wait for each other and for room in B
    resp_o.aw_ready = req_i.w_valid && req_i.b_ready;
    resp_o.w_ready  = req_i.aw_valid && req_i.b_ready;
    // Response pushed in the same cycle as the pop
    resp_o.b_valid  = req_i.aw_valid && req_i.w_valid;
    resp_o.b.resp   = wr_ok ? RESP_OKAY : RESP_SLVERR;
    // Reads only need room in R
    resp_o.ar_ready = req_i.r_ready;
    resp_o.r_valid  = req_i.ar_valid;
    resp_o.r.resp   = rd_ok ? RESP_OKAY : RESP_SLVERR;
    // Zero data on error
    resp_o.r.data   = rd_ok ? rd_row_data : '0;
  end

endmodule

//--- gpio_sync.sv
/*
  Flop chain on the pin inputs against metastability.
  Adds SYNC_STAGES cycles of latency. Glitches shorter than a cycle may be lost.
*/
module gpio_sync
  import gpio_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [AXI_DATA_WIDTH-1:0] gpio_i,
  output logic [AXI_DATA_WIDTH-1:0] gpio_in_o
);

  // Stage 0 samples the raw pins
  logic [SYNC_STAGES-1:0][AXI_DATA_WIDTH-1:0] sync_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is safe to use
  assign gpio_in_o = sync_q[SYNC_STAGES-1];

endmodule

//--- axi_gpio.sv
/*
  Memory-mapped 32-bit GPIO on an AXI4-Lite slave port.
  Pads are split into out, output enable, pull enable and input. The pad itself
  is resolved outside. Single clock domain, no interrupts.
*/
module axi_gpio
  import gpio_pkg::*;
#(
  parameter int FIFO_DEPTH  = 4,
  parameter int SYNC_STAGES = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // AXI4-Lite slave port
  input  axi4l_req_t                req_i,
  output axi4l_resp_t               resp_o,
  // Split pad signals
  input  logic [AXI_DATA_WIDTH-1:0] gpio_i,
  output logic [AXI_DATA_WIDTH-1:0] gpio_o,
  output logic [AXI_DATA_WIDTH-1:0] gpio_oe_o,
  output logic [AXI_DATA_WIDTH-1:0] gpio_pull_o
);

  // Buffered bus between FIFOs and registers
  axi4l_req_t                req_buf;
  axi4l_resp_t               resp_buf;
  // Pins after the synchronizer
  logic [AXI_DATA_WIDTH-1:0] gpio_in_sync;

  axi_lite_buffer #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) axi_lite_buffer_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (req_i),
    .resp_o (resp_o),
    .req_o  (req_buf),
    .resp_i (resp_buf)
  );

  gpio_regfile gpio_regfile_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_buf),
    .resp_o     (resp_buf),
    .gpio_in_i  (gpio_in_sync),
    .gpio_o     (gpio_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_pull_o(gpio_pull_o)
  );

  gpio_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) gpio_sync_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .gpio_i   (gpio_i),
    .gpio_in_o(gpio_in_sync)
  );

endmodule

//--- tb_axi_gpio_chk.sv
/*
  Port checks bound into axi_gpio.
  Response channels must hold valid and payload until taken.
*/
module tb_axi_gpio_chk
  import gpio_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input axi4l_req_t  req_i,
  input axi4l_resp_t resp_o,
  input logic [31:0] gpio_o,
  input logic [31:0] gpio_oe_o,
  input logic [31:0] gpio_pull_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // B held until b_ready
  b_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_o.b_valid && !req_i.b_ready |=> resp_o.b_valid && $stable(resp_o.b))
    else $error("B channel dropped or changed before ready");

  // R held until r_ready
  r_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_o.r_valid && !req_i.r_ready |=> resp_o.r_valid && $stable(resp_o.r))
    else $error("R channel dropped or changed before ready");

  // Pins quiet during reset
  reset_pins_a : assert property (@(posedge clk_i)
    !rst_n_i |-> (gpio_o == '0) && (gpio_oe_o == '0) && (gpio_pull_o == '0))
    else $error("GPIO outputs not zero in reset");

endmodule

bind axi_gpio tb_axi_gpio_chk chk_i (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_i      (req_i),
  .resp_o     (resp_o),
  .gpio_o     (gpio_o),
  .gpio_oe_o  (gpio_oe_o),
  .gpio_pull_o(gpio_pull_o)
);

//--- tb_axi_gpio.sv
/*
  Directed testbench for the AXI4-Lite GPIO.
  Pads are resolved here from out, enable, pull and a driven value.
  Runs single-threaded on the bus, one outstanding request per task call.
*/
module tb_axi_gpio
  import gpio_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIFO_DEPTH     = 4;
  localparam int SYNC_STAGES    = 2;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam logic [31:0] ADDR_RDATA = 32'(ROW_RDATA);
  localparam logic [31:0] ADDR_WDATA = 32'(ROW_WDATA);
  localparam logic [31:0] ADDR_WEN   = 32'(ROW_WEN);
  localparam logic [31:0] ADDR_PULL  = 32'(ROW_PULL);

  logic        clk;
  logic        rst_n;
  axi4l_req_t  req;
  axi4l_resp_t resp;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_oe;
  logic [31:0] gpio_pull;
  // Testbench side of the pad
  logic [31:0] drv_mask;
  logic [31:0] drv_val;
  // Register model
  logic [31:0] m_wdata;
  logic [31:0] m_wen;
  logic [31:0] m_pull;
  logic [31:0] rng_state;
  int          cycle_cnt;

  axi_gpio #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .SYNC_STAGES(SYNC_STAGES)
  ) axi_gpio_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .resp_o     (resp),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .gpio_pull_o(gpio_pull)
  );

  // Pad resolution, enabled output wins, then the external driver, then pull
  assign gpio_in = (gpio_oe & gpio_out) | (~gpio_oe & drv_mask & drv_val)
                 | (~gpio_oe & ~drv_mask & gpio_pull);

  always #50 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Byte lanes from strobe bits, as a mask
  function automatic logic [31:0] lane_update(
    input logic [31:0] old_v,
    input logic [31:0] new_v,
    input logic [3:0]  strb
  );
    logic [31:0] m;
    m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~m) | (new_v & m);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Called and left 1 ns after a rising edge
  task automatic axi_write(input logic [31:0] addr, input logic [2:0] prot,
                           input logic [31:0] data, input logic [3:0] strb,
                           output logic [1:0] bresp);
    logic aw_done;
    logic w_done;
    logic aw_fire;
    logic w_fire;
    aw_done = 1'b0;
    w_done = 1'b0;
    req.aw.addr = addr;
    req.aw.prot = prot;
    req.w.data = data;
    req.w.strb = strb;
    req.aw_valid = 1'b1;
    req.w_valid = 1'b1;
    req.b_ready = 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      aw_fire = req.aw_valid && resp.aw_ready;
      w_fire = req.w_valid && resp.w_ready;
      step();
      if (aw_fire) begin
        req.aw_valid = 1'b0;
        aw_done = 1'b1;
      end
      if (w_fire) begin
        req.w_valid = 1'b0;
        w_done = 1'b1;
      end
    end
    do begin
      @(negedge clk);
    end while (!resp.b_valid);
    bresp = resp.b.resp;
    step();
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [2:0] prot,
                          output logic [31:0] data, output logic [1:0] rresp);
    logic ar_fire;
    req.ar.addr = addr;
    req.ar.prot = prot;
    req.ar_valid = 1'b1;
    req.r_ready = 1'b1;
    do begin
      @(negedge clk);
      ar_fire = resp.ar_ready;
      step();
    end while (!ar_fire);
    req.ar_valid = 1'b0;
    do begin
      @(negedge clk);
    end while (!resp.r_valid);
    data = resp.r.data;
    rresp = resp.r.resp;
    step();
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] d;
    logic [1:0]  r;
    axi_read(addr, 3'b000, d, r);
    check({name, " resp"}, 32'(r), 32'(RESP_OKAY));
    check(name, d, exp);
  endtask

  function automatic logic [31:0] model_row(input logic [31:0] addr);
    if (addr == ADDR_WDATA) return m_wdata;
    if (addr == ADDR_WEN) return m_wen;
    return m_pull;
  endfunction

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    check("gpio_o", gpio_out, '0);
    check("gpio_oe_o", gpio_oe, '0);
    check("gpio_pull_o", gpio_pull, '0);
    read_expect(ADDR_WDATA, '0, "wdata");
    read_expect(ADDR_WEN, '0, "wen");
    read_expect(ADDR_PULL, '0, "pull");
  endtask

  task automatic test_strobed_write();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  r;
    for (int i = 0; i < 40; i++) begin
      case (next_rand() % 3)
        0: addr = ADDR_WDATA;
        1: addr = ADDR_WEN;
        default: addr = ADDR_PULL;
      endcase
      data = next_rand();
      strb = next_rand() & 32'hf;
      axi_write(addr, 3'b000, data, strb, r);
      check("bresp", 32'(r), 32'(RESP_OKAY));
      if (addr == ADDR_WDATA) m_wdata = lane_update(m_wdata, data, strb);
      else if (addr == ADDR_WEN) m_wen = lane_update(m_wen, data, strb);
      else m_pull = lane_update(m_pull, data, strb);
      read_expect(addr, model_row(addr), "readback");
      check("gpio_o", gpio_out, m_wdata);
      check("gpio_oe_o", gpio_oe, m_wen);
      check("gpio_pull_o", gpio_pull, m_pull);
    end
  endtask

  task automatic test_input_path();
    logic [1:0]  r;
    logic [31:0] exp;
    m_wen = next_rand();
    axi_write(ADDR_WEN, 3'b000, m_wen, 4'hf, r);
    check("bresp wen", 32'(r), 32'(RESP_OKAY));
    m_pull = next_rand();
    axi_write(ADDR_PULL, 3'b000, m_pull, 4'hf, r);
    check("bresp pull", 32'(r), 32'(RESP_OKAY));
    drv_mask = next_rand();
    drv_val = next_rand();
    repeat (SYNC_STAGES + 2) step();
    exp = (m_wen & m_wdata) | (~m_wen & drv_mask & drv_val) | (~m_wen & ~drv_mask & m_pull);
    read_expect(ADDR_RDATA, exp, "rdata");
  endtask

  task automatic test_errors();
    logic [1:0]  r;
    logic [31:0] d;
    axi_write(ADDR_RDATA, 3'b000, 32'hdead_beef, 4'hf, r);
    check("bresp input row", 32'(r), 32'(RESP_SLVERR));
    axi_write(32'h10, 3'b000, 32'hdead_beef, 4'hf, r);
    check("bresp 0x10", 32'(r), 32'(RESP_SLVERR));
    // Out of range but aliases the output data row in the low bits
    axi_write(32'h14, 3'b000, 32'hfeed_f00d, 4'hf, r);
    check("bresp 0x14", 32'(r), 32'(RESP_SLVERR));
    axi_write(ADDR_WDATA, 3'b010, 32'hdead_beef, 4'hf, r);
    check("bresp prot", 32'(r), 32'(RESP_SLVERR));
    axi_read(ADDR_WDATA, 3'b010, d, r);
    check("rresp prot", 32'(r), 32'(RESP_SLVERR));
    check("rdata prot", d, '0);
    axi_read(32'h20, 3'b000, d, r);
    check("rresp 0x20", 32'(r), 32'(RESP_SLVERR));
    check("rdata 0x20", d, '0);
    read_expect(ADDR_WDATA, m_wdata, "wdata kept");
    read_expect(ADDR_WEN, m_wen, "wen kept");
    read_expect(ADDR_PULL, m_pull, "pull kept");
  endtask

  task automatic test_backpressure();
    int          accepted;
    int          got;
    logic        stop;
    logic [31:0] last;
    logic [31:0] exp_q[$];
    // Stalled write responses
    accepted = 0;
    stop = 1'b0;
    req.b_ready = 1'b0;
    req.aw.addr = ADDR_WDATA;
    req.aw.prot = 3'b000;
    req.w.strb = 4'hf;
    req.w.data = next_rand();
    req.aw_valid = 1'b1;
    req.w_valid = 1'b1;
    while (!stop) begin
      @(negedge clk);
      check("w_ready", 32'(resp.w_ready), 32'(resp.aw_ready));
      if (resp.aw_ready) begin
        accepted++;
        last = req.w.data;
        step();
        req.w.data = next_rand();
      end else begin
        stop = 1'b1;
        step();
        req.aw_valid = 1'b0;
        req.w_valid = 1'b0;
      end
    end
    // B FIFO plus AW and W FIFOs full
    check("accepted writes", 32'(accepted), 32'(2 * FIFO_DEPTH));
    req.b_ready = 1'b1;
    got = 0;
    while (got < accepted) begin
      @(negedge clk);
      if (resp.b_valid) begin
        check("bresp stalled", 32'(resp.b.resp), 32'(RESP_OKAY));
        got++;
      end
      step();
    end
    repeat (4) begin
      @(negedge clk);
      check("extra b_valid", 32'(resp.b_valid), 0);
    end
    step();
    m_wdata = last;
    read_expect(ADDR_WDATA, m_wdata, "last write");

    // Stalled read responses, alternating rows
    stop = 1'b0;
    req.r_ready = 1'b0;
    req.ar.prot = 3'b000;
    req.ar.addr = ADDR_WDATA;
    req.ar_valid = 1'b1;
    while (!stop) begin
      @(negedge clk);
      if (resp.ar_ready) begin
        exp_q.push_back(model_row(req.ar.addr));
        step();
        req.ar.addr = (req.ar.addr == ADDR_WDATA) ? ADDR_WEN : ADDR_WDATA;
      end else begin
        stop = 1'b1;
        step();
        req.ar_valid = 1'b0;
      end
    end
    // R FIFO plus AR FIFO full
    check("accepted reads", 32'(exp_q.size()), 32'(2 * FIFO_DEPTH));
    req.r_ready = 1'b1;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      if (resp.r_valid) begin
        check("rresp stalled", 32'(resp.r.resp), 32'(RESP_OKAY));
        check("rdata order", resp.r.data, exp_q.pop_front());
      end
      step();
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b1;
    req = '0;
    drv_mask = '0;
    drv_val = '0;
    m_wdata = '0;
    m_wen = '0;
    m_pull = '0;
    rng_state = 32'h8d9a;
    cycle_cnt = 0;
    #5;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    step();
    test_reset_state();
    test_strobed_write();
    test_input_path();
    test_errors();
    test_backpressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- all.f
gpio_pkg.sv
axi_lite_fifo.sv
axi_lite_buffer.sv
gpio_regfile.sv
gpio_sync.sv
axi_gpio.sv
tb_axi_gpio_chk.sv
tb_axi_gpio.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi_gpio
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
